// ==== ipod_pkg.sv ====
`default_nettype none

package ipod_pkg;

  // ==========================================================================
  // Widths with a meaning
  // ==========================================================================
  typedef logic [22:0] flash_addr_t;
  typedef logic [31:0] flash_word_t;
  typedef logic [15:0] sample_t;
  // Upper 23 bits are the word address, bit 0 picks the half
  typedef logic [23:0] sample_idx_t;
  typedef logic [15:0] divisor_t;

  // Avalon-style flash read port
  typedef struct packed {
    logic        read;
    flash_addr_t address;
  } flash_req_t;

  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_t readdata;
  } flash_rsp_t;

  // Sample stream toward the audio sink
  typedef struct packed {
    logic    valid;
    sample_t data;
  } sample_out_t;

  typedef enum logic [1:0] {IDLE, FETCH, WAIT_DATA, EMIT} player_state_t;

  // ==========================================================================
  // Keyboard command codes
  // ==========================================================================
  localparam logic [7:0] ASCII_E_UP = 8'h45;
  localparam logic [7:0] ASCII_E_LO = 8'h65;
  localparam logic [7:0] ASCII_D_UP = 8'h44;
  localparam logic [7:0] ASCII_D_LO = 8'h64;
  localparam logic [7:0] ASCII_F_UP = 8'h46;
  localparam logic [7:0] ASCII_F_LO = 8'h66;
  localparam logic [7:0] ASCII_B_UP = 8'h42;
  localparam logic [7:0] ASCII_B_LO = 8'h62;
  localparam logic [7:0] ASCII_R_UP = 8'h52;
  localparam logic [7:0] ASCII_R_LO = 8'h72;

endpackage

`default_nettype wire

// ==== kbd_command_decoder.sv ====
`default_nettype none

module kbd_command_decoder (
  input  wire logic       CLK_50M,
  input  wire logic       rst_n,
  input  wire logic [7:0] kbd_ascii,
  input  wire logic       kbd_strobe,
  output logic            playing,
  output logic            backward,
  output logic            restart
);

  logic is_restart;

  // Restart key in either case
  assign is_restart = (kbd_ascii == ipod_pkg::ASCII_R_UP) ||
                      (kbd_ascii == ipod_pkg::ASCII_R_LO);

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      playing  <= 1'b0;
      backward <= 1'b0;
      restart  <= 1'b0;
    end
    else
    begin
      // One-cycle pulse per strobed R
      restart <= kbd_strobe && is_restart;
      if (kbd_strobe)
      begin
        case (kbd_ascii)
          ipod_pkg::ASCII_E_UP, ipod_pkg::ASCII_E_LO:
            playing <= 1'b1;
          ipod_pkg::ASCII_D_UP, ipod_pkg::ASCII_D_LO:
            playing <= 1'b0;
          ipod_pkg::ASCII_F_UP, ipod_pkg::ASCII_F_LO:
            backward <= 1'b0;
          ipod_pkg::ASCII_B_UP, ipod_pkg::ASCII_B_LO:
            backward <= 1'b1;
          default:
          begin
            // Other keys leave the flags alone
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== sample_rate_gen.sv ====
`default_nettype none

module sample_rate_gen #(
  parameter ipod_pkg::divisor_t DIV_DEFAULT = 16'd40,
  parameter ipod_pkg::divisor_t DIV_STEP    = 16'd8,
  parameter ipod_pkg::divisor_t DIV_MIN     = 16'd16,
  parameter ipod_pkg::divisor_t DIV_MAX     = 16'd80
) (
  input  wire logic          CLK_50M,
  input  wire logic          rst_n,
  input  wire logic          speed_up,
  input  wire logic          speed_down,
  input  wire logic          speed_reset,
  output ipod_pkg::divisor_t rate_divisor,
  output logic               sample_tick
);

  ipod_pkg::divisor_t tick_cnt;

  // Tick on the reload cycle, one every rate_divisor cycles
  assign sample_tick = (tick_cnt == '0);

  // ==========================================================================
  // Saturating speed divisor
  // ==========================================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      rate_divisor <= DIV_DEFAULT;
    else if (speed_reset)
      rate_divisor <= DIV_DEFAULT;
    else if (speed_up)
      rate_divisor <= (rate_divisor < DIV_MIN + DIV_STEP) ? DIV_MIN : rate_divisor - DIV_STEP;
    else if (speed_down)
      rate_divisor <= (rate_divisor > DIV_MAX - DIV_STEP) ? DIV_MAX : rate_divisor + DIV_STEP;
  end

  // Down-counter, picks up a new divisor only at reload
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      tick_cnt <= DIV_DEFAULT - 16'd1;
    else if (sample_tick)
      tick_cnt <= rate_divisor - 16'd1;
    else
      tick_cnt <= tick_cnt - 16'd1;
  end

  a_divisor_range : assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    (rate_divisor >= DIV_MIN) && (rate_divisor <= DIV_MAX)
  );

endmodule

`default_nettype wire

// ==== sample_index_gen.sv ====
`default_nettype none

module sample_index_gen #(
  parameter ipod_pkg::flash_addr_t ADDR_LAST = 23'd63
) (
  input  wire logic             CLK_50M,
  input  wire logic             rst_n,
  input  wire logic             advance,
  input  wire logic             backward,
  input  wire logic             restart,
  output ipod_pkg::sample_idx_t position
);

  // High half of the last word is the final sample
  localparam ipod_pkg::sample_idx_t POS_LAST = {ADDR_LAST, 1'b1};

  ipod_pkg::sample_idx_t pos_next;

  always_comb
  begin
    if (backward)
      pos_next = (position == '0) ? POS_LAST : position - 24'd1;
    else
      pos_next = (position == POS_LAST) ? '0 : position + 24'd1;
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      position <= '0;
    else if (restart)
      // Restart wins over a step in the same cycle
      position <= '0;
    else if (advance)
      position <= pos_next;
  end

endmodule

`default_nettype wire

// ==== word_unpacker.sv ====
`default_nettype none

module word_unpacker (
  input  wire logic                  CLK_50M,
  input  wire logic                  rst_n,
  input  wire ipod_pkg::sample_idx_t position,
  input  wire logic                  load,
  input  wire ipod_pkg::flash_addr_t load_addr,
  input  wire ipod_pkg::flash_word_t load_word,
  output logic                       hit,
  output ipod_pkg::sample_t          sample
);

  logic                  buf_valid;
  ipod_pkg::flash_addr_t buf_addr;
  ipod_pkg::flash_word_t buf_word;

  // Buffer holds the word under the current position
  assign hit = buf_valid && (buf_addr == position[23:1]);

  // Bit 0 picks the half, low half first
  assign sample = position[0] ? buf_word[31:16] : buf_word[15:0];

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      buf_valid <= 1'b0;
    else if (load)
      buf_valid <= 1'b1;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (load)
    begin
      buf_addr <= load_addr;
      buf_word <= load_word;
    end
  end

endmodule

`default_nettype wire

// ==== player_ctrl.sv ====
`default_nettype none

module player_ctrl #(
  parameter int CREDITS = 4
) (
  input  wire logic                  CLK_50M,
  input  wire logic                  rst_n,
  input  wire logic                  playing,
  input  wire logic                  sample_tick,
  input  wire logic                  hit,
  input  wire ipod_pkg::sample_t     sample,
  input  wire ipod_pkg::flash_rsp_t  flash_rsp,
  input  wire ipod_pkg::sample_idx_t position,
  input  wire logic                  credit_return,
  output ipod_pkg::flash_req_t       flash_req,
  output logic                       load,
  output ipod_pkg::flash_addr_t      load_addr,
  output logic                       advance,
  output ipod_pkg::sample_out_t      sample_out
);

  localparam int CW = $clog2(CREDITS + 1);

  ipod_pkg::player_state_t state;
  ipod_pkg::player_state_t state_next;
  ipod_pkg::flash_addr_t   req_addr;
  logic [CW-1:0]           credit_cnt;
  logic                    pending;
  logic                    emit;

  // ==========================================================================
  // Outputs
  // ==========================================================================
  assign emit       = (state == ipod_pkg::EMIT) && hit && playing && (credit_cnt != '0);
  assign advance    = emit;
  assign sample_out = '{valid: emit, data: sample};
  assign flash_req  = '{read: (state == ipod_pkg::FETCH), address: req_addr};
  // Word is captured from the flash in the readdatavalid cycle
  assign load       = (state == ipod_pkg::WAIT_DATA) && flash_rsp.readdatavalid;
  assign load_addr  = req_addr;

  always_comb
  begin
    state_next = state;
    unique case (state)
      ipod_pkg::IDLE:
        if (pending && playing)
          state_next = hit ? ipod_pkg::EMIT : ipod_pkg::FETCH;
      ipod_pkg::FETCH:
        if (!flash_rsp.waitrequest)
          state_next = ipod_pkg::WAIT_DATA;
      ipod_pkg::WAIT_DATA:
        if (flash_rsp.readdatavalid)
          state_next = ipod_pkg::EMIT;
      ipod_pkg::EMIT:
        // A restart can move the position off the buffered word
        if (!hit)
          state_next = ipod_pkg::FETCH;
        else if (emit)
          state_next = ipod_pkg::IDLE;
      default:
        state_next = ipod_pkg::IDLE;
    endcase
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= ipod_pkg::IDLE;
      req_addr   <= '0;
      pending    <= 1'b0;
      credit_cnt <= CW'(CREDITS);
    end
    else
    begin
      state <= state_next;
      // Address is frozen for the whole read
      if ((state_next == ipod_pkg::FETCH) && (state != ipod_pkg::FETCH))
        req_addr <= position[23:1];
      // Extra ticks while pending merge into one sample
      pending <= (pending && !emit) || (sample_tick && playing);
      if (credit_return && !emit)
        credit_cnt <= credit_cnt + 1'b1;
      else if (!credit_return && emit)
        credit_cnt <= credit_cnt - 1'b1;
    end
  end

  a_credit_max : assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    credit_cnt <= CW'(CREDITS)
  );

  a_addr_hold : assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.address)
  );

  // Spending the last credit blocks the next cycle
  a_no_valid_without_credit : assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    sample_out.valid && (credit_cnt == CW'(1)) && !credit_return |=> !sample_out.valid
  );

endmodule

`default_nettype wire

// ==== ipod_top.sv ====
`default_nettype none

module ipod_top #(
  parameter ipod_pkg::divisor_t   DIV_DEFAULT = 16'd40,
  parameter ipod_pkg::divisor_t   DIV_STEP    = 16'd8,
  parameter ipod_pkg::divisor_t   DIV_MIN     = 16'd16,
  parameter ipod_pkg::divisor_t   DIV_MAX     = 16'd80,
  parameter ipod_pkg::flash_addr_t ADDR_LAST  = 23'd63,
  parameter int                   CREDITS     = 4
) (
  input  wire logic                 CLK_50M,
  input  wire logic                 rst_n,
  input  wire logic [7:0]           kbd_ascii,
  input  wire logic                 kbd_strobe,
  input  wire logic                 speed_up,
  input  wire logic                 speed_down,
  input  wire logic                 speed_reset,
  output ipod_pkg::flash_req_t      flash_req,
  input  wire ipod_pkg::flash_rsp_t flash_rsp,
  output ipod_pkg::sample_out_t     sample_out,
  input  wire logic                 credit_return,
  output ipod_pkg::divisor_t        rate_divisor
);

  logic                  playing;
  logic                  backward;
  logic                  restart;
  logic                  sample_tick;
  logic                  advance;
  logic                  load;
  logic                  hit;
  ipod_pkg::flash_addr_t load_addr;
  ipod_pkg::sample_idx_t position;
  ipod_pkg::sample_t     sample;

  // ==========================================================================
  // Command and timing sources
  // ==========================================================================
  kbd_command_decoder i_kbd (
    .CLK_50M(CLK_50M), .rst_n(rst_n), .kbd_ascii(kbd_ascii), .kbd_strobe(kbd_strobe),
    .playing(playing), .backward(backward), .restart(restart)
  );

  sample_rate_gen #(
    .DIV_DEFAULT(DIV_DEFAULT), .DIV_STEP(DIV_STEP), .DIV_MIN(DIV_MIN), .DIV_MAX(DIV_MAX)
  ) i_rate (
    .CLK_50M(CLK_50M), .rst_n(rst_n), .speed_up(speed_up), .speed_down(speed_down),
    .speed_reset(speed_reset), .rate_divisor(rate_divisor), .sample_tick(sample_tick)
  );

  // ==========================================================================
  // Datapath and controller
  // ==========================================================================
  sample_index_gen #(.ADDR_LAST(ADDR_LAST)) i_index (
    .CLK_50M(CLK_50M), .rst_n(rst_n), .advance(advance), .backward(backward),
    .restart(restart), .position(position)
  );

  // Flash data goes straight into the buffer
  word_unpacker i_unpack (
    .CLK_50M(CLK_50M), .rst_n(rst_n), .position(position), .load(load),
    .load_addr(load_addr), .load_word(flash_rsp.readdata), .hit(hit), .sample(sample)
  );

  player_ctrl #(.CREDITS(CREDITS)) i_ctrl (
    .CLK_50M(CLK_50M), .rst_n(rst_n), .playing(playing), .sample_tick(sample_tick),
    .hit(hit), .sample(sample), .flash_rsp(flash_rsp), .position(position),
    .credit_return(credit_return), .flash_req(flash_req), .load(load),
    .load_addr(load_addr), .advance(advance), .sample_out(sample_out)
  );

endmodule

`default_nettype wire

// ==== tb_flash_model.sv ====
`default_nettype none

module tb_flash_model #(
  parameter int          SEED     = 16,
  parameter logic [15:0] DATA_KEY = 16'hA5C3
) (
  input  wire logic                 CLK_50M,
  input  wire logic                 rst_n,
  input  wire ipod_pkg::flash_req_t flash_req,
  output ipod_pkg::flash_rsp_t      flash_rsp,
  output logic                      overlap
);
  timeunit 1ns;
  timeprecision 1ps;

  integer                seed = SEED;
  logic                  busy;
  logic                  stall;
  int                    lat_cnt;
  ipod_pkg::flash_addr_t addr;

  // Half h of word a holds (a * 2 + h) ^ DATA_KEY
  function automatic ipod_pkg::flash_word_t word_at(input ipod_pkg::flash_addr_t a);
    logic [15:0] lo;
    logic [15:0] hi;
    lo = 16'(32'(a) * 32'd2) ^ DATA_KEY;
    hi = 16'(32'(a) * 32'd2 + 32'd1) ^ DATA_KEY;
    return {hi, lo};
  endfunction

  // Read port driven on the falling edge, the DUT samples it on the rising edge
  always @(negedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy      <= 1'b0;
      lat_cnt   <= 0;
      addr      <= '0;
      overlap   <= 1'b0;
      flash_rsp <= '0;
    end
    else
    begin
      stall = ($random(seed) & 3) == 0;
      flash_rsp.waitrequest   <= stall;
      flash_rsp.readdatavalid <= 1'b0;
      if (busy && (lat_cnt == 1))
      begin
        flash_rsp.readdatavalid <= 1'b1;
        flash_rsp.readdata      <= word_at(addr);
        busy                    <= 1'b0;
      end
      else if (busy)
        lat_cnt <= lat_cnt - 1;
      // Second request before the data came back
      if (flash_req.read && busy)
        overlap <= 1'b1;
      if (flash_req.read && !stall)
      begin
        busy    <= 1'b1;
        addr    <= flash_req.address;
        lat_cnt <= 1 + ($random(seed) & 32'h7fffffff) % 6;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_ipod.sv ====
`default_nettype none

module tb_ipod;
  timeunit 1ns;
  timeprecision 1ps;

  // ==========================================================================
  // Test constants
  // ==========================================================================
  localparam int          SEED_INIT   = 16;
  localparam int          N_SAMPLES   = 400;
  localparam int          CMD_START   = 140;    // after one full forward wrap
  localparam int          IDLE_CYCLES = 300;
  localparam int          DIV_DEFAULT = 40;
  localparam int          DIV_STEP    = 8;
  localparam int          DIV_MIN     = 16;
  localparam int          DIV_MAX     = 80;
  localparam int          ADDR_LAST   = 63;
  localparam int          CREDITS     = 4;
  localparam int          POS_LAST    = ADDR_LAST * 2 + 1;
  localparam int          WATCHDOG    = IDLE_CYCLES + N_SAMPLES * DIV_MAX * 4;
  localparam logic [15:0] DATA_KEY    = 16'hA5C3;

  logic                   CLK_50M;
  logic                   rst_n;
  logic [7:0]             kbd_ascii;
  logic                   kbd_strobe;
  logic                   speed_up;
  logic                   speed_down;
  logic                   speed_reset;
  logic                   credit_return;
  logic                   overlap;
  ipod_pkg::flash_req_t   flash_req;
  ipod_pkg::flash_rsp_t   flash_rsp;
  ipod_pkg::sample_out_t  sample_out;
  ipod_pkg::divisor_t     rate_divisor;

  // Reference model state
  integer seed = SEED_INIT;
  int     exp_pos;
  int     exp_div;
  int     outstanding;
  int     sample_cnt;
  int     cycle_cnt;
  int     pause_cnt;
  int     pause_len;
  bit     exp_back;
  bit     exp_playing;
  bit     saw_full;

  ipod_top #(
    .DIV_DEFAULT(16'(DIV_DEFAULT)), .DIV_STEP(16'(DIV_STEP)), .DIV_MIN(16'(DIV_MIN)),
    .DIV_MAX(16'(DIV_MAX)), .ADDR_LAST(23'(ADDR_LAST)), .CREDITS(CREDITS)
  ) i_dut (
    .CLK_50M(CLK_50M), .rst_n(rst_n), .kbd_ascii(kbd_ascii), .kbd_strobe(kbd_strobe),
    .speed_up(speed_up), .speed_down(speed_down), .speed_reset(speed_reset),
    .flash_req(flash_req), .flash_rsp(flash_rsp), .sample_out(sample_out),
    .credit_return(credit_return), .rate_divisor(rate_divisor)
  );

  tb_flash_model #(.SEED(SEED_INIT), .DATA_KEY(DATA_KEY)) i_flash (
    .CLK_50M(CLK_50M), .rst_n(rst_n), .flash_req(flash_req), .flash_rsp(flash_rsp),
    .overlap(overlap)
  );

  always #10 CLK_50M = ~CLK_50M;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected)
      report_error($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected));
  endtask

  // Word is pos / 2 and half is pos % 2
  function automatic logic [15:0] expected_sample(input int pos);
    return 16'((pos / 2) * 2 + (pos % 2)) ^ DATA_KEY;
  endfunction

  function automatic int next_pos(input int pos, input bit back);
    if (back)
      return (pos == 0) ? POS_LAST : pos - 1;
    return (pos == POS_LAST) ? 0 : pos + 1;
  endfunction

  task automatic press_key(input logic [7:0] code);
    kbd_ascii  = code;
    kbd_strobe = 1'b1;
  endtask

  task automatic give_command();
    int         pick;
    logic [7:0] code;
    pick = ($random(seed) & 32'h7fffffff) % 6;
    case (pick)
      0:
      begin
        code        = "E";
        exp_playing = 1'b1;
      end
      1:
      begin
        code        = "D";
        exp_playing = 1'b0;
        pause_cnt   = 0;
        pause_len   = 40 + ($random(seed) & 32'h7fffffff) % 200;
      end
      2:
      begin
        code     = "F";
        exp_back = 1'b0;
      end
      3:
      begin
        code     = "B";
        exp_back = 1'b1;
      end
      4:
      begin
        code    = "R";
        exp_pos = 0;
      end
      default:
        code = "X";
    endcase
    // Lower case form of the same key
    if ($random(seed) & 1)
      code = code | 8'h20;
    press_key(code);
  endtask

  task automatic check_cycle();
    cycle_cnt++;
    compare_value("rate_divisor", 32'(rate_divisor), 32'(exp_div));
    if (overlap)
      report_error("Flash read issued while another read was outstanding");
    if (sample_out.valid)
    begin
      if (!exp_playing)
        report_error("Sample emitted while playback was paused");
      if (outstanding >= CREDITS)
        report_error("Sample emitted with no credit left");
      compare_value("sample_out.data", 32'(sample_out.data), 32'(expected_sample(exp_pos)));
      outstanding++;
      if (outstanding == CREDITS)
        saw_full = 1'b1;
      sample_cnt++;
      exp_pos = next_pos(exp_pos, exp_back);
      if ((sample_cnt >= CMD_START) && (($random(seed) & 7) == 0))
        give_command();
    end
    else if (!exp_playing)
    begin
      pause_cnt++;
      if (pause_cnt >= pause_len)
      begin
        press_key("E");
        exp_playing = 1'b1;
      end
    end
  endtask

  task automatic drive_credit();
    bit withhold;
    // Sink stops returning credits for part of every 2000 cycles
    withhold = (cycle_cnt % 2000) >= 1400;
    if (!withhold && (outstanding > 0) && (($random(seed) & 3) == 0))
    begin
      credit_return = 1'b1;
      outstanding--;
    end
  endtask

  task automatic drive_speed();
    int r;
    r = $random(seed) & 255;
    if (r < 3)
    begin
      // Slow-down and speed-up phases take turns so both limits are hit
      if (((cycle_cnt / 4000) % 2) == 0)
      begin
        speed_down = 1'b1;
        exp_div    = (exp_div + DIV_STEP > DIV_MAX) ? DIV_MAX : exp_div + DIV_STEP;
      end
      else
      begin
        speed_up = 1'b1;
        exp_div  = (exp_div - DIV_STEP < DIV_MIN) ? DIV_MIN : exp_div - DIV_STEP;
      end
    end
    else if ((r == 3) && (($random(seed) & 7) == 0))
    begin
      speed_reset = 1'b1;
      exp_div     = DIV_DEFAULT;
    end
  endtask

  // ==========================================================================
  // Stimulus and checking on the falling edge
  // ==========================================================================
  initial
  begin
    CLK_50M       = 1'b0;
    rst_n         = 1'b0;
    kbd_ascii     = 8'h00;
    kbd_strobe    = 1'b0;
    speed_up      = 1'b0;
    speed_down    = 1'b0;
    speed_reset   = 1'b0;
    credit_return = 1'b0;
    exp_pos       = 0;
    exp_div       = DIV_DEFAULT;
    exp_back      = 1'b0;
    exp_playing   = 1'b0;
    outstanding   = 0;
    sample_cnt    = 0;
    cycle_cnt     = 0;
    pause_cnt     = 0;
    pause_len     = 0;
    saw_full      = 1'b0;
    repeat (2) @(posedge CLK_50M);
    @(negedge CLK_50M);
    rst_n = 1'b1;
    // Nothing may move while paused after reset
    repeat (IDLE_CYCLES)
    begin
      @(negedge CLK_50M);
      compare_value("sample_out.valid", 32'(sample_out.valid), 32'd0);
      compare_value("flash_req.read", 32'(flash_req.read), 32'd0);
      compare_value("rate_divisor", 32'(rate_divisor), 32'(DIV_DEFAULT));
    end
    press_key("E");
    exp_playing = 1'b1;
    while (sample_cnt < N_SAMPLES)
    begin
      @(negedge CLK_50M);
      kbd_strobe    = 1'b0;
      speed_up      = 1'b0;
      speed_down    = 1'b0;
      speed_reset   = 1'b0;
      credit_return = 1'b0;
      check_cycle();
      drive_credit();
      drive_speed();
    end
    if (!saw_full)
      report_error("Output never used up all credits");
    else
    begin
      $display("Test OK");
      $finish;
    end
  end

  initial
  begin
    repeat (WATCHDOG) @(posedge CLK_50M);
    report_error("Timeout before all samples were checked");
  end

endmodule

`default_nettype wire

// ==== ipod.f ====
ipod_pkg.sv
kbd_command_decoder.sv
sample_rate_gen.sv
sample_index_gen.sv
word_unpacker.sv
player_ctrl.sv
ipod_top.sv
tb_flash_model.sv
tb_ipod.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ipod
FILELIST  ?= ipod.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
